/* tb.f */
+incdir+verification
rtl/msg_pkg.sv
rtl/sync_fifo.sv
rtl/border_combiner.sv
rtl/border_splitter.sv
rtl/message_handler.sv
verification/tb_message_handler.sv

/* run_sim.sh */
#!/bin/sh
# Builds the message handler testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f tb.f \
    --top-module tb_message_handler \
    -Mdir obj_dir \
    -o sim_message_handler

./obj_dir/sim_message_handler > sim.log 2>&1 || true
cat sim.log

if grep -q "^test passed$" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

/* verification/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors   = 0;
int timeout_errors = 0;

task automatic check_link(input string name, input link_word_t expected,
                          input link_word_t actual);
    if (actual !== expected) begin
        value_errors++;
        $display("ERR %s expected %h actual %h", name, expected, actual);
    end
endtask

task automatic check_border(input string name, input border_word_t expected,
                            input border_word_t actual);
    if (actual !== expected) begin
        value_errors++;
        $display("ERR %s expected %h actual %h", name, expected, actual);
    end
endtask

task automatic check_flags(input string name, input logic [NUM_CH-1:0] expected,
                           input logic [NUM_CH-1:0] actual);
    if (actual !== expected) begin
        value_errors++;
        $display("ERR %s expected %h actual %h", name, expected, actual);
    end
endtask

// Waits until the DUT has taken every queued input word.
task automatic wait_inputs_taken(input int limit, input string what);
    int cycles;
    cycles = 0;
    while (pending_count() != 0 && cycles < limit) begin
        @(negedge clk);
        cycles++;
    end
    if (pending_count() != 0) begin
        timeout_errors++;
        $display("Timeout in %s: %0d input words were never accepted", what, pending_count());
        flush_queues();
    end
endtask

// Waits until every input is taken and every expected output has arrived.
task automatic wait_until_idle(input int limit, input string what);
    int cycles;
    cycles = 0;
    while ((pending_count() + expected_count()) != 0 && cycles < limit) begin
        @(negedge clk);
        cycles++;
    end
    if ((pending_count() + expected_count()) != 0) begin
        timeout_errors++;
        $display("Timeout in %s: %0d inputs unsent and %0d outputs missing", what,
                 pending_count(), expected_count());
        flush_queues();
    end
endtask

`endif

/* verification/tb_message_handler.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_message_handler
    import msg_pkg::*;
();

    localparam int NUM_CH      = 5;
    localparam int FIFO_DEPTH  = 8;
    localparam int NUM_SRC     = 2 * NUM_CH + 1;
    localparam int CTRL_SRC    = 2 * NUM_CH;
    localparam int HALF_PERIOD = 20;

    logic                      clk;
    logic                      reset;
    node_id_t                  fpga_id;
    link_word_t                link_in_data;
    logic                      link_in_valid;
    logic                      link_in_ready;
    link_word_t                link_out_data;
    logic                      link_out_valid;
    logic                      link_out_ready;
    border_word_t [NUM_CH-1:0] north_in_data;
    logic [NUM_CH-1:0]         north_in_valid;
    logic [NUM_CH-1:0]         north_in_ready;
    border_word_t [NUM_CH-1:0] south_in_data;
    logic [NUM_CH-1:0]         south_in_valid;
    logic [NUM_CH-1:0]         south_in_ready;
    border_word_t [NUM_CH-1:0] north_out_data;
    logic [NUM_CH-1:0]         north_out_valid;
    logic [NUM_CH-1:0]         north_out_ready;
    border_word_t [NUM_CH-1:0] south_out_data;
    logic [NUM_CH-1:0]         south_out_valid;
    logic [NUM_CH-1:0]         south_out_ready;
    link_word_t                ctrl_in_data;
    logic                      ctrl_in_valid;
    logic                      ctrl_in_ready;
    link_word_t                ctrl_out_data;
    logic                      ctrl_out_valid;
    logic                      ctrl_out_ready;

    // Index of a border source or sink: north channel c is c, south channel c is NUM_CH + c.
    border_word_t pend_border_q [2*NUM_CH][$];
    link_word_t   pend_ctrl_q [$];
    link_word_t   pend_link_q [$];
    link_word_t   exp_link_q [NUM_SRC][$];
    border_word_t exp_border_q [2*NUM_CH][$];
    link_word_t   exp_ctrl_q [$];
    integer       seed;

    function automatic int pending_count();
        int n;
        n = pend_ctrl_q.size() + pend_link_q.size();
        for (int i = 0; i < 2 * NUM_CH; i++) begin
            n += pend_border_q[i].size();
        end
        return n;
    endfunction

    function automatic int expected_count();
        int n;
        n = exp_ctrl_q.size();
        for (int i = 0; i < NUM_SRC; i++) begin
            n += exp_link_q[i].size();
        end
        for (int i = 0; i < 2 * NUM_CH; i++) begin
            n += exp_border_q[i].size();
        end
        return n;
    endfunction

    function automatic void flush_queues();
        pend_ctrl_q.delete();
        pend_link_q.delete();
        exp_ctrl_q.delete();
        for (int i = 0; i < NUM_SRC; i++) begin
            exp_link_q[i].delete();
        end
        for (int i = 0; i < 2 * NUM_CH; i++) begin
            pend_border_q[i].delete();
            exp_border_q[i].delete();
        end
    endfunction

`include "tb_checks.svh"

    message_handler #(
        .NUM_CHANNELS (NUM_CH),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) dut0 (
        .clk             (clk),
        .reset           (reset),
        .fpga_id         (fpga_id),
        .link_in_data    (link_in_data),
        .link_in_valid   (link_in_valid),
        .link_in_ready   (link_in_ready),
        .link_out_data   (link_out_data),
        .link_out_valid  (link_out_valid),
        .link_out_ready  (link_out_ready),
        .north_in_data   (north_in_data),
        .north_in_valid  (north_in_valid),
        .north_in_ready  (north_in_ready),
        .south_in_data   (south_in_data),
        .south_in_valid  (south_in_valid),
        .south_in_ready  (south_in_ready),
        .north_out_data  (north_out_data),
        .north_out_valid (north_out_valid),
        .north_out_ready (north_out_ready),
        .south_out_data  (south_out_data),
        .south_out_valid (south_out_valid),
        .south_out_ready (south_out_ready),
        .ctrl_in_data    (ctrl_in_data),
        .ctrl_in_valid   (ctrl_in_valid),
        .ctrl_in_ready   (ctrl_in_ready),
        .ctrl_out_data   (ctrl_out_data),
        .ctrl_out_valid  (ctrl_out_valid),
        .ctrl_out_ready  (ctrl_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    function automatic link_word_t random_link();
        link_word_t w;
        w = {$random(seed), $random(seed)};
        return w;
    endfunction

    // Expected link word for a border word, stamped with the neighbour id.
    function automatic link_word_t stamped(input int bank, input int chan,
                                           input border_word_t payload);
        link_word_t w;
        w         = '0;
        w.dest_id = (bank == 1) ? fpga_id + 8'd1 : fpga_id - 8'd1;
        w.dir     = (bank == 1);
        w.chan    = 7'(chan);
        w.payload = payload;
        return w;
    endfunction

    task automatic send_border(input int bank, input int chan, input border_word_t payload);
        pend_border_q[bank*NUM_CH+chan].push_back(payload);
        exp_link_q[bank*NUM_CH+chan].push_back(stamped(bank, chan, payload));
    endtask

    task automatic send_ctrl_up(input link_word_t w);
        w.chan = CONTROL_CHAN;
        pend_ctrl_q.push_back(w);
        exp_link_q[CTRL_SRC].push_back(w);
    endtask

    task automatic send_link_in(input int bank, input int chan, input border_word_t payload);
        link_word_t w;
        w         = random_link();
        w.dir     = (bank == 1);
        w.chan    = 7'(chan);
        w.payload = payload;
        pend_link_q.push_back(w);
        // Tags past the last channel are dropped by the DUT.
        if (chan < NUM_CH) begin
            exp_border_q[bank*NUM_CH+chan].push_back(payload);
        end
    endtask

    task automatic send_ctrl_down(input link_word_t w);
        w.chan = CONTROL_CHAN;
        pend_link_q.push_back(w);
        exp_ctrl_q.push_back(w);
    endtask

    task automatic present_heads();
        for (int i = 0; i < NUM_CH; i++) begin
            north_in_valid[i] = (pend_border_q[i].size() != 0);
            north_in_data[i]  = north_in_valid[i] ? pend_border_q[i][0] : '0;
            south_in_valid[i] = (pend_border_q[NUM_CH+i].size() != 0);
            south_in_data[i]  = south_in_valid[i] ? pend_border_q[NUM_CH+i][0] : '0;
        end
        ctrl_in_valid = (pend_ctrl_q.size() != 0);
        ctrl_in_data  = ctrl_in_valid ? pend_ctrl_q[0] : '0;
        link_in_valid = (pend_link_q.size() != 0);
        link_in_data  = link_in_valid ? pend_link_q[0] : '0;
    endtask

    task automatic take_border(input int idx, input string name, input border_word_t actual);
        if (exp_border_q[idx].size() == 0) begin
            value_errors++;
            $display("Unexpected word %h on %s", actual, name);
        end else begin
            check_border(name, exp_border_q[idx].pop_front(), actual);
        end
    endtask

    task automatic take_link_out(input link_word_t w);
        int idx;
        idx = -1;
        if (w.chan == CONTROL_CHAN) begin
            idx = CTRL_SRC;
        end else if (int'(w.chan) < NUM_CH) begin
            idx = int'(w.dir) * NUM_CH + int'(w.chan);
        end
        if (idx < 0 || exp_link_q[idx].size() == 0) begin
            value_errors++;
            $display("Unexpected word %h on link_out", w);
        end else begin
            check_link("link_out_data", exp_link_q[idx].pop_front(), w);
        end
    endtask

    // Called just before the rising edge, so it sees exactly the transfers of that edge.
    task automatic sample_and_check();
        for (int i = 0; i < NUM_CH; i++) begin
            if (north_in_valid[i] && north_in_ready[i]) begin
                void'(pend_border_q[i].pop_front());
            end
            if (south_in_valid[i] && south_in_ready[i]) begin
                void'(pend_border_q[NUM_CH+i].pop_front());
            end
            if (north_out_valid[i] && north_out_ready[i]) begin
                take_border(i, $sformatf("north_out_data[%0d]", i), north_out_data[i]);
            end
            if (south_out_valid[i] && south_out_ready[i]) begin
                take_border(NUM_CH + i, $sformatf("south_out_data[%0d]", i), south_out_data[i]);
            end
        end
        if (ctrl_in_valid && ctrl_in_ready) begin
            void'(pend_ctrl_q.pop_front());
        end
        if (link_in_valid && link_in_ready) begin
            void'(pend_link_q.pop_front());
        end
        if (link_out_valid && link_out_ready) begin
            take_link_out(link_out_data);
        end
        if (ctrl_out_valid && ctrl_out_ready) begin
            if (exp_ctrl_q.size() == 0) begin
                value_errors++;
                $display("Unexpected word %h on ctrl_out", ctrl_out_data);
            end else begin
                check_link("ctrl_out_data", exp_ctrl_q.pop_front(), ctrl_out_data);
            end
        end
    endtask

    // Input streams and the output monitors share one process.
    initial begin
        north_in_valid = '0;
        north_in_data  = '0;
        south_in_valid = '0;
        south_in_data  = '0;
        ctrl_in_valid  = 1'b0;
        ctrl_in_data   = '0;
        link_in_valid  = 1'b0;
        link_in_data   = '0;
        forever begin
            @(negedge clk);
            present_heads();
            #(HALF_PERIOD - 1);
            if (!reset) begin
                sample_and_check();
            end
        end
    end

    task automatic set_fpga_id(input node_id_t id);
        fpga_id = id;
        // Stamped ids follow fpga_id after two cycles.
        repeat (2) @(negedge clk);
    endtask

    task automatic test_north_out();
        set_fpga_id(8'h00);
        for (int c = 0; c < NUM_CH; c++) begin
            send_border(0, c, $random(seed));
        end
        wait_until_idle(200, "north words to link_out");
    endtask

    task automatic test_south_out();
        set_fpga_id(8'hff);
        for (int c = 0; c < NUM_CH; c++) begin
            send_border(1, c, $random(seed));
        end
        wait_until_idle(200, "south words to link_out");
    endtask

    task automatic test_control_mixed();
        set_fpga_id(8'h42);
        send_ctrl_up(random_link());
        wait_until_idle(100, "single control word");
        for (int k = 0; k < 4; k++) begin
            send_ctrl_up(random_link());
            send_border(0, 2, $random(seed));
            send_border(1, 4, $random(seed));
        end
        wait_until_idle(300, "mixed north, south and control words");
    endtask

    task automatic test_link_to_border();
        for (int d = 0; d < 2; d++) begin
            for (int c = 0; c < NUM_CH; c++) begin
                send_link_in(d, c, $random(seed));
            end
        end
        send_link_in(0, 20, $random(seed));
        send_link_in(1, NUM_CH, $random(seed));
        wait_until_idle(300, "link_in words to the border banks");
    endtask

    task automatic test_ctrl_backpressure();
        ctrl_out_ready = 1'b0;
        for (int k = 0; k < 4; k++) begin
            send_ctrl_down(random_link());
        end
        send_link_in(1, 0, $random(seed));
        wait_inputs_taken(100, "control words into the input FIFO");
        repeat (10) @(negedge clk);
        if (exp_ctrl_q.size() != 4 || exp_border_q[NUM_CH].size() != 1) begin
            value_errors++;
            $display("Words moved past ctrl_out while its ready was low");
        end else begin
            check_link("ctrl_out_data", exp_ctrl_q[0], ctrl_out_data);
        end
        if (ctrl_out_valid !== 1'b1) begin
            value_errors++;
            $display("ctrl_out_valid dropped while a control word was waiting");
        end
        ctrl_out_ready = 1'b1;
        wait_until_idle(200, "control words after ctrl_out_ready rose");
    endtask

    task automatic test_link_backpressure();
        link_out_ready = 1'b0;
        for (int k = 0; k < 4; k++) begin
            for (int c = 0; c < NUM_CH; c++) begin
                send_border(0, c, $random(seed));
                send_border(1, c, $random(seed));
            end
        end
        repeat (60) @(negedge clk);
        check_flags("north_in_ready", '0, north_in_ready);
        check_flags("south_in_ready", '0, south_in_ready);
        // The output FIFO and the two combiner registers hold the rest.
        if (pending_count() != 8 * NUM_CH - (FIFO_DEPTH + 2)) begin
            value_errors++;
            $display("Expected %0d border words held at the inputs, found %0d",
                     8 * NUM_CH - (FIFO_DEPTH + 2), pending_count());
        end
        link_out_ready = 1'b1;
        wait_until_idle(1000, "border words after link_out_ready rose");
    endtask

    initial begin
        seed            = 32'h3964_ce3b;
        reset           = 1'b1;
        fpga_id         = '0;
        link_out_ready  = 1'b1;
        north_out_ready = '1;
        south_out_ready = '1;
        ctrl_out_ready  = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (link_in_ready !== 1'b1 || ctrl_in_ready !== 1'b1) begin
            value_errors++;
            $display("Input readies were low in the first cycle after reset");
        end
        test_north_out();
        test_south_out();
        test_control_mixed();
        test_link_to_border();
        test_ctrl_backpressure();
        test_link_backpressure();
        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/message_handler.sv */
`timescale 1ns/100ps
`default_nettype none

module message_handler
    import msg_pkg::*;
#(
    parameter int NUM_CHANNELS = DEFAULT_NUM_CHANNELS,
    parameter int FIFO_DEPTH   = DEFAULT_FIFO_DEPTH
) (
    input  logic                            clk,
    input  logic                            reset,
    input  node_id_t                        fpga_id,

    input  link_word_t                      link_in_data,
    input  logic                            link_in_valid,
    output logic                            link_in_ready,

    output link_word_t                      link_out_data,
    output logic                            link_out_valid,
    input  logic                            link_out_ready,

    input  border_word_t [NUM_CHANNELS-1:0] north_in_data,
    input  logic [NUM_CHANNELS-1:0]         north_in_valid,
    output logic [NUM_CHANNELS-1:0]         north_in_ready,

    input  border_word_t [NUM_CHANNELS-1:0] south_in_data,
    input  logic [NUM_CHANNELS-1:0]         south_in_valid,
    output logic [NUM_CHANNELS-1:0]         south_in_ready,

    output border_word_t [NUM_CHANNELS-1:0] north_out_data,
    output logic [NUM_CHANNELS-1:0]         north_out_valid,
    input  logic [NUM_CHANNELS-1:0]         north_out_ready,

    output border_word_t [NUM_CHANNELS-1:0] south_out_data,
    output logic [NUM_CHANNELS-1:0]         south_out_valid,
    input  logic [NUM_CHANNELS-1:0]         south_out_ready,

    input  link_word_t                      ctrl_in_data,
    input  logic                            ctrl_in_valid,
    output logic                            ctrl_in_ready,

    output link_word_t                      ctrl_out_data,
    output logic                            ctrl_out_valid,
    input  logic                            ctrl_out_ready
);

    link_word_t in_fifo_data;
    logic       in_fifo_valid;
    logic       in_fifo_ready;

    link_word_t arb_data;
    logic       arb_valid;
    logic       out_fifo_ready;

    link_word_t north_comb_data;
    logic       north_comb_valid;
    logic       north_comb_ready;
    link_word_t south_comb_data;
    logic       south_comb_valid;
    logic       south_comb_ready;

    node_id_t   north_id;
    node_id_t   south_id;
    link_word_t north_stamped;
    link_word_t south_stamped;

    logic       is_ctrl;
    logic       north_split_valid;
    logic       north_split_ready;
    logic       south_split_valid;
    logic       south_split_ready;

    sync_fifo #(
        .payload_t (link_word_t),
        .DEPTH     (FIFO_DEPTH)
    ) in_fifo (
        .clk          (clk),
        .reset        (reset),
        .input_data   (link_in_data),
        .input_valid  (link_in_valid),
        .input_ready  (link_in_ready),
        .output_data  (in_fifo_data),
        .output_valid (in_fifo_valid),
        .output_ready (in_fifo_ready)
    );

    sync_fifo #(
        .payload_t (link_word_t),
        .DEPTH     (FIFO_DEPTH)
    ) out_fifo (
        .clk          (clk),
        .reset        (reset),
        .input_data   (arb_data),
        .input_valid  (arb_valid),
        .input_ready  (out_fifo_ready),
        .output_data  (link_out_data),
        .output_valid (link_out_valid),
        .output_ready (link_out_ready)
    );

    border_combiner #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) north_combiner (
        .clk       (clk),
        .reset     (reset),
        .in_data   (north_in_data),
        .in_valid  (north_in_valid),
        .in_ready  (north_in_ready),
        .out_data  (north_comb_data),
        .out_valid (north_comb_valid),
        .out_ready (north_comb_ready)
    );

    border_combiner #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) south_combiner (
        .clk       (clk),
        .reset     (reset),
        .in_data   (south_in_data),
        .in_valid  (south_in_valid),
        .in_ready  (south_in_ready),
        .out_data  (south_comb_data),
        .out_valid (south_comb_valid),
        .out_ready (south_comb_ready)
    );

    // Neighbour ids wrap modulo 256.
    always_ff @(posedge clk) begin
        if (reset) begin
            north_id <= '0;
            south_id <= '0;
        end else begin
            north_id <= fpga_id - 8'd1;
            south_id <= fpga_id + 8'd1;
        end
    end

    always_comb begin
        north_stamped         = north_comb_data;
        north_stamped.dest_id = north_id;
        north_stamped.dir     = DIR_NORTH;
        south_stamped         = south_comb_data;
        south_stamped.dest_id = south_id;
        south_stamped.dir     = DIR_SOUTH;
    end

    // Fixed priority towards the link goes north, then south, then control.
    // Control is ready whenever neither bank claims the slot.
    always_comb begin
        arb_data         = north_stamped;
        arb_valid        = 1'b0;
        north_comb_ready = 1'b0;
        south_comb_ready = 1'b0;
        ctrl_in_ready    = 1'b0;
        if (out_fifo_ready) begin
            if (north_comb_valid) begin
                arb_valid        = 1'b1;
                north_comb_ready = 1'b1;
            end else if (south_comb_valid) begin
                arb_data         = south_stamped;
                arb_valid        = 1'b1;
                south_comb_ready = 1'b1;
            end else begin
                arb_data      = ctrl_in_data;
                arb_valid     = ctrl_in_valid;
                ctrl_in_ready = 1'b1;
            end
        end
    end

    // Incoming words go to control by tag, otherwise to a bank by direction.
    assign is_ctrl           = (in_fifo_data.chan == CONTROL_CHAN);
    assign ctrl_out_data     = in_fifo_data;
    assign ctrl_out_valid    = in_fifo_valid && is_ctrl;
    assign north_split_valid = in_fifo_valid && !is_ctrl && (in_fifo_data.dir == DIR_NORTH);
    assign south_split_valid = in_fifo_valid && !is_ctrl && (in_fifo_data.dir == DIR_SOUTH);

    always_comb begin
        if (is_ctrl) begin
            in_fifo_ready = ctrl_out_ready;
        end else if (in_fifo_data.dir == DIR_SOUTH) begin
            in_fifo_ready = south_split_ready;
        end else begin
            in_fifo_ready = north_split_ready;
        end
    end

    border_splitter #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) north_splitter (
        .in_data   (in_fifo_data),
        .in_valid  (north_split_valid),
        .in_ready  (north_split_ready),
        .out_data  (north_out_data),
        .out_valid (north_out_valid),
        .out_ready (north_out_ready)
    );

    border_splitter #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) south_splitter (
        .in_data   (in_fifo_data),
        .in_valid  (south_split_valid),
        .in_ready  (south_split_ready),
        .out_data  (south_out_data),
        .out_valid (south_out_valid),
        .out_ready (south_out_ready)
    );

endmodule

`default_nettype wire

/* rtl/border_splitter.sv */
`timescale 1ns/100ps
`default_nettype none

module border_splitter
    import msg_pkg::*;
#(
    parameter int NUM_CHANNELS = DEFAULT_NUM_CHANNELS
) (
    input  link_word_t                      in_data,
    input  logic                            in_valid,
    output logic                            in_ready,

    output border_word_t [NUM_CHANNELS-1:0] out_data,
    output logic [NUM_CHANNELS-1:0]         out_valid,
    input  logic [NUM_CHANNELS-1:0]         out_ready
);

    // Every channel sees the payload; only the tagged one gets valid.
    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            out_data[c] = in_data.payload;
        end
    end

    always_comb begin
        // A tag past the last channel is accepted and dropped,
        // so a bad word cannot block the link.
        in_ready = 1'b1;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            out_valid[c] = 1'b0;
            if (in_data.chan == 7'(c)) begin
                out_valid[c] = in_valid;
                in_ready     = out_ready[c];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/border_combiner.sv */
`timescale 1ns/100ps
`default_nettype none

module border_combiner
    import msg_pkg::*;
#(
    parameter int NUM_CHANNELS = DEFAULT_NUM_CHANNELS
) (
    input  logic                            clk,
    input  logic                            reset,

    input  border_word_t [NUM_CHANNELS-1:0] in_data,
    input  logic [NUM_CHANNELS-1:0]         in_valid,
    output logic [NUM_CHANNELS-1:0]         in_ready,

    output link_word_t                      out_data,
    output logic                            out_valid,
    input  logic                            out_ready
);

    localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] grant_idx;
    logic             grant_found;
    logic             load;
    link_word_t       next_word;

    // Search for a valid channel starting at the round-robin pointer.
    always_comb begin
        int idx;
        grant_idx   = rr_ptr;
        grant_found = 1'b0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            idx = int'(rr_ptr) + i;
            if (idx >= NUM_CHANNELS) begin
                idx = idx - NUM_CHANNELS;
            end
            if (!grant_found && in_valid[idx]) begin
                grant_found = 1'b1;
                grant_idx   = IDX_W'(idx);
            end
        end
    end

    // The output register refills when it is empty or drains this cycle.
    assign load = grant_found && (!out_valid || out_ready);

    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            in_ready[c] = load && (grant_idx == IDX_W'(c));
        end
    end

    always_comb begin
        next_word         = '0;
        next_word.chan    = 7'(grant_idx);
        next_word.payload = in_data[grant_idx];
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= next_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            rr_ptr    <= '0;
        end else begin
            if (load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            // Next search starts just past the channel served.
            if (load) begin
                if (grant_idx == IDX_W'(NUM_CHANNELS - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= grant_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/sync_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [63:0],
    parameter int  DEPTH     = 64
) (
    input  logic     clk,
    input  logic     reset,

    input  payload_t input_data,
    input  logic     input_valid,
    output logic     input_ready,

    output payload_t output_data,
    output logic     output_valid,
    input  logic     output_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    // Pointers wrap explicitly so that DEPTH need not be a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // The head entry is presented directly, so a word written into an
    // empty FIFO is visible one cycle later.
    assign output_valid = (count != '0);
    assign output_data  = mem[rd_ptr];

    // A full FIFO still takes a word in a cycle where the head leaves.
    assign input_ready = (count != CNT_W'(DEPTH)) || output_ready;

    assign do_write = input_valid && input_ready;
    assign do_read  = output_valid && output_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= input_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/msg_pkg.sv */
`default_nettype none

package msg_pkg;

    // One 64-bit word on the transceiver link.
    typedef struct packed {
        logic [7:0]  dest_id;
        logic        dir;
        logic [6:0]  chan;
        logic [15:0] spare;
        logic [31:0] payload;
    } link_word_t;

    // One word on a local border channel.
    typedef logic [31:0] border_word_t;

    typedef logic [7:0] node_id_t;

    // Direction bit values of a link word.
    localparam logic DIR_NORTH = 1'b0;
    localparam logic DIR_SOUTH = 1'b1;

    // A link word with this channel tag is a control message, whatever its direction.
    localparam logic [6:0] CONTROL_CHAN = 7'h7f;

    // Defaults for the top-level parameters.
    // The channel count has to stay below CONTROL_CHAN.
    localparam int DEFAULT_NUM_CHANNELS = 5;
    localparam int DEFAULT_FIFO_DEPTH   = 64;

endpackage

`default_nettype wire
